/* all.f */
+incdir+hdl
hdl/pic_pkg.sv
hdl/input_sync.sv
hdl/bus_interface.sv
hdl/pic_control.sv
hdl/request_register.sv
hdl/priority_resolver.sv
hdl/in_service_register.sv
hdl/pic_8259.sv
sim/pic_tb.sv

/* hdl/bus_interface.sv */
`timescale 1ns/1ps

`include "pic_config.svh"

module bus_interface
    import pic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       a0,
    input  logic [7:0] d_in,
    input  logic       inta_n,
    output wr_event_t  wr_ev,
    output logic       inta_fall,
    output logic       inta_rise,
    output logic       rd_a0,
    input  logic [7:0] rd_data,
    output logic [7:0] d_out
);

    bus_pins_t pins_raw;
    bus_pins_t pins_s;
    bus_pins_t pins_prev;
    logic      inta_s;
    logic      inta_prev;
    logic      rd_active;
    logic      inta_active;

    assign pins_raw = '{cs_n, rd_n, wr_n, a0, d_in};

    input_sync #(.T(bus_pins_t), .STAGES(`PIC_SYNC_STAGES), .RST_VAL('1)) u_bus_sync (
        .clk       (clk),
        .rst       (rst),
        .din       (pins_raw),
        .dout      (pins_s),
        .dout_prev (pins_prev)
    );

    input_sync #(.T(logic), .STAGES(`PIC_SYNC_STAGES), .RST_VAL(1'b1)) u_inta_sync (
        .clk       (clk),
        .rst       (rst),
        .din       (inta_n),
        .dout      (inta_s),
        .dout_prev (inta_prev)
    );

    // ----------------------------------------
    // Write and INTA edges
    // ----------------------------------------
    always_comb
    begin
        wr_ev.valid = ~pins_prev.cs_n & ~pins_prev.wr_n & pins_s.wr_n;  // wr_n rise
        wr_ev.a0    = pins_prev.a0;
        wr_ev.data  = pins_prev.data;  // Value held while wr_n was low
    end

    assign inta_fall = inta_prev & ~inta_s;
    assign inta_rise = ~inta_prev & inta_s;

    // ----------------------------------------
    // Read data
    // ----------------------------------------
    assign rd_a0       = pins_s.a0;
    assign rd_active   = ~pins_s.cs_n & ~pins_s.rd_n;
    assign inta_active = ~inta_s;  // Control returns 0 on the first pulse

    always_ff @(posedge clk)
    begin
        if (rst)
            d_out <= '0;
        else if (rd_active || inta_active)
            d_out <= rd_data;
        else
            d_out <= '0;  // Bus idles low
    end

    // Host keeps its writes at least 4 cycles apart
    assert property (@(posedge clk) disable iff (rst)
        wr_ev.valid |=> !wr_ev.valid ##1 !wr_ev.valid ##1 !wr_ev.valid);

endmodule

/* hdl/in_service_register.sv */
`timescale 1ns/1ps

module in_service_register
    import pic_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  isr_cmd_t isr_cmd,
    input  level_t   isr_level,
    output irq_vec_t isr
);

    irq_vec_t set_bits;
    irq_vec_t clr_bits;

    always_comb
    begin
        set_bits = '0;
        clr_bits = '0;
        if (isr_cmd.ack_set)
            set_bits[isr_cmd.level] = 1'b1;
        if (isr_cmd.clear_top)
            clr_bits[isr_level] = 1'b1;  // Top in-service level
        if (isr_cmd.clear_level)
            clr_bits[isr_cmd.level] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            isr <= '0;
        else
            isr <= (isr & ~clr_bits) | set_bits;
    end

    // Resolver never grants a level already in service
    assert property (@(posedge clk) disable iff (rst)
        isr_cmd.ack_set |-> !isr[isr_cmd.level]);

endmodule

/* hdl/input_sync.sv */
`timescale 1ns/1ps

module input_sync #(
    parameter type T       = logic,
    parameter int  STAGES  = 2,
    parameter T    RST_VAL = '0     // Idle level of the pins
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout,
    output T     dout_prev
);

    T stage [STAGES];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < STAGES; i++)
                stage[i] <= RST_VAL;
            dout_prev <= RST_VAL;
        end
        else
        begin
            stage[0] <= din;
            for (int i = 1; i < STAGES; i++)
                stage[i] <= stage[i-1];
            dout_prev <= stage[STAGES-1];  // One cycle behind dout, for edges
        end
    end

    assign dout = stage[STAGES-1];

    // Edge logic downstream relies on this pairing
    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> dout_prev == $past(dout));

endmodule

/* hdl/pic_8259.sv */
`timescale 1ns/1ps

module pic_8259
    import pic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       a0,
    input  logic [7:0] d_in,
    input  logic       inta_n,
    input  irq_vec_t   ir,
    output logic [7:0] d_out,
    output logic       int_req
);

    wr_event_t  wr_ev;
    logic       inta_fall;
    logic       inta_rise;
    logic       rd_a0;
    logic [7:0] rd_data;
    pic_cfg_t   cfg;
    irq_vec_t   mask;
    isr_cmd_t   isr_cmd;
    logic       ack;
    level_t     ack_level;
    irq_vec_t   irr;
    irq_vec_t   isr;
    logic       pend_valid;
    level_t     pend_level;
    logic       isr_valid;
    level_t     isr_level;
    logic       int_wanted;

    bus_interface u_bus (
        .clk       (clk),
        .rst       (rst),
        .cs_n      (cs_n),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .a0        (a0),
        .d_in      (d_in),
        .inta_n    (inta_n),
        .wr_ev     (wr_ev),
        .inta_fall (inta_fall),
        .inta_rise (inta_rise),
        .rd_a0     (rd_a0),
        .rd_data   (rd_data),
        .d_out     (d_out)
    );

    pic_control u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr_ev      (wr_ev),
        .inta_fall  (inta_fall),
        .inta_rise  (inta_rise),
        .rd_a0      (rd_a0),
        .pend_valid (pend_valid),
        .pend_level (pend_level),
        .int_wanted (int_wanted),
        .irr        (irr),
        .isr        (isr),
        .cfg        (cfg),
        .mask       (mask),
        .isr_cmd    (isr_cmd),
        .ack        (ack),
        .ack_level  (ack_level),
        .rd_data    (rd_data),
        .int_req    (int_req)
    );

    request_register u_irr (
        .clk       (clk),
        .rst       (rst),
        .ir        (ir),
        .ltim      (cfg.ltim),
        .ack       (ack),
        .ack_level (ack_level),
        .irr       (irr)
    );

    priority_resolver u_prio (
        .clk        (clk),
        .rst        (rst),
        .irr        (irr),
        .mask       (mask),
        .isr        (isr),
        .isr_cmd    (isr_cmd),
        .pend_valid (pend_valid),
        .pend_level (pend_level),
        .isr_valid  (isr_valid),
        .isr_level  (isr_level),
        .int_wanted (int_wanted)
    );

    in_service_register u_isr (
        .clk       (clk),
        .rst       (rst),
        .isr_cmd   (isr_cmd),
        .isr_level (isr_level),
        .isr       (isr)
    );

endmodule

/* hdl/pic_config.svh */
`ifndef PIC_CONFIG_SVH
`define PIC_CONFIG_SVH

// Request lines on one device
`define PIC_LINES 8

// Level number width, log2 of the line count
`define PIC_LEVEL_W 3

// Vector base from ICW2 bits 7:3
`define PIC_VEC_BASE_W 5

// Flop stages on every pin input
`define PIC_SYNC_STAGES 2

`endif

/* hdl/pic_control.sv */
`timescale 1ns/1ps

`include "pic_config.svh"

module pic_control
    import pic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wr_event_t  wr_ev,
    input  logic       inta_fall,
    input  logic       inta_rise,
    input  logic       rd_a0,
    input  logic       pend_valid,
    input  level_t     pend_level,
    input  logic       int_wanted,
    input  irq_vec_t   irr,
    input  irq_vec_t   isr,
    output pic_cfg_t   cfg,
    output irq_vec_t   mask,
    output isr_cmd_t   isr_cmd,
    output logic       ack,
    output level_t     ack_level,
    output logic [7:0] rd_data,
    output logic       int_req
);

    typedef enum logic [1:0] {INIT_ICW1, INIT_ICW2, INIT_ICW4, INIT_READY} init_state_t;
    typedef enum logic [1:0] {ACK_IDLE, ACK_P1, ACK_GAP, ACK_P2} ack_state_t;

    init_state_t init_state;
    ack_state_t  ack_state;
    logic        ic4;         // ICW4 expected
    read_sel_t   read_sel;
    level_t      vec_level;   // Level frozen at first INTA
    logic        ack_hit;     // First INTA found a live request
    logic        is_icw1;
    logic        is_ocw2;
    logic        is_ocw3;
    logic [2:0]  ocw2_code;
    logic        aeoi_clear;

    assign is_icw1 = wr_ev.valid && !wr_ev.a0 && wr_ev.data[ICW1_FLAG];
    assign is_ocw2 = wr_ev.valid && !wr_ev.a0 && init_state == INIT_READY
                     && wr_ev.data[OCW_TAG_LSB +: 2] == OCW2_TAG;
    assign is_ocw3 = wr_ev.valid && !wr_ev.a0 && init_state == INIT_READY
                     && wr_ev.data[OCW_TAG_LSB +: 2] == OCW3_TAG;
    assign ocw2_code = wr_ev.data[OCW2_CODE_LSB +: 3];

    // ----------------------------------------
    // Init sequence and configuration
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            init_state <= INIT_ICW1;
            cfg        <= '0;
            ic4        <= 1'b0;
            mask       <= '0;
            read_sel   <= SEL_IRR;
        end
        else if (is_icw1)  // Restarts init from any state
        begin
            init_state <= INIT_ICW2;
            cfg.ltim   <= wr_ev.data[ICW1_LTIM];
            cfg.aeoi   <= 1'b0;  // Off unless ICW4 sets it
            ic4        <= wr_ev.data[ICW1_IC4];
            mask       <= '0;
            read_sel   <= SEL_IRR;
        end
        else if (wr_ev.valid && wr_ev.a0)
        begin
            case (init_state)
                INIT_ICW2:
                begin
                    cfg.vector_base <= wr_ev.data[7 -: `PIC_VEC_BASE_W];
                    init_state      <= ic4 ? INIT_ICW4 : INIT_READY;
                end
                INIT_ICW4:
                begin
                    cfg.aeoi   <= wr_ev.data[ICW4_AEOI];  // uPM ignored
                    init_state <= INIT_READY;
                end
                INIT_READY: mask <= wr_ev.data;  // OCW1
                default: ;
            endcase
        end
        else if (is_ocw3 && wr_ev.data[OCW3_RR])
            read_sel <= wr_ev.data[OCW3_RIS] ? SEL_ISR : SEL_IRR;
    end

    // ----------------------------------------
    // INTA sequence
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            ack_state <= ACK_IDLE;
        else
            case (ack_state)
                ACK_IDLE: if (inta_fall) ack_state <= ACK_P1;
                ACK_P1:   if (inta_rise) ack_state <= ACK_GAP;
                ACK_GAP:  if (inta_fall) ack_state <= ACK_P2;
                ACK_P2:   if (inta_rise) ack_state <= ACK_IDLE;
            endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ack_hit <= 1'b0;
        else if (inta_fall && ack_state == ACK_IDLE)
            ack_hit <= pend_valid;
    end

    always_ff @(posedge clk)
        if (inta_fall && ack_state == ACK_IDLE)
            vec_level <= pend_valid ? pend_level : '1;  // Spurious request answers IR7

    assign ack        = inta_fall && ack_state == ACK_IDLE && pend_valid;
    assign ack_level  = pend_level;
    assign aeoi_clear = inta_rise && ack_state == ACK_P2 && ack_hit && cfg.aeoi;

    // ISR commands, acknowledge first
    always_comb
    begin
        isr_cmd = '0;
        if (ack)
        begin
            isr_cmd.ack_set = 1'b1;
            isr_cmd.level   = pend_level;
        end
        else if (aeoi_clear)
            isr_cmd.clear_top = 1'b1;
        else if (is_icw1)
        begin
            isr_cmd.set_prio = 1'b1;  // IR7 lowest again
            isr_cmd.level    = '1;
        end
        else if (is_ocw2)
        begin
            isr_cmd.level = wr_ev.data[`PIC_LEVEL_W-1:0];
            case (ocw2_code)
                OCW2_NSEOI:     isr_cmd.clear_top   = 1'b1;
                OCW2_SEOI:      isr_cmd.clear_level = 1'b1;
                OCW2_SET_PRIO:  isr_cmd.set_prio    = 1'b1;
                OCW2_ROT_NSEOI:
                begin
                    isr_cmd.clear_top = 1'b1;
                    isr_cmd.rotate    = 1'b1;
                end
                default: ;  // Other codes ignored
            endcase
        end
    end

    // ----------------------------------------
    // Read mux and INT
    // ----------------------------------------
    always_comb
    begin
        if (ack_state == ACK_P2 || (ack_state == ACK_GAP && inta_fall))
            rd_data = {cfg.vector_base, vec_level};  // 8086 vector
        else if (ack_state == ACK_P1 || (ack_state == ACK_IDLE && inta_fall))
            rd_data = '0;  // First pulse carries no data
        else if (rd_a0)
            rd_data = mask;
        else
            rd_data = (read_sel == SEL_ISR) ? isr : irr;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            int_req <= 1'b0;
        else  // Held low from first INTA to second rise
            int_req <= init_state == INIT_READY && ack_state == ACK_IDLE
                       && !inta_fall && int_wanted;
    end

    // Acknowledged level is a live unmasked request
    assert property (@(posedge clk) disable iff (rst)
        ack |-> irr[ack_level] && !mask[ack_level]);

endmodule

/* hdl/pic_pkg.sv */
`include "pic_config.svh"

package pic_pkg;

    typedef logic [`PIC_LINES-1:0]   irq_vec_t;  // One bit per IR line
    typedef logic [`PIC_LEVEL_W-1:0] level_t;    // IR level number

    // Strobes, address and data share one synchronizer so they stay aligned
    typedef struct packed {
        logic       cs_n;
        logic       rd_n;
        logic       wr_n;
        logic       a0;
        logic [7:0] data;
    } bus_pins_t;

    // One-cycle record of a finished host write
    typedef struct packed {
        logic       valid;
        logic       a0;
        logic [7:0] data;
    } wr_event_t;

    typedef struct packed {
        logic                       ltim;         // Level triggered
        logic                       aeoi;         // Automatic EOI
        logic [`PIC_VEC_BASE_W-1:0] vector_base;  // Vector bits 7:3
    } pic_cfg_t;

    typedef enum logic {SEL_IRR, SEL_ISR} read_sel_t;

    typedef struct packed {
        logic   ack_set;      // Set ISR bit of level
        logic   clear_top;    // Non-specific or automatic EOI
        logic   clear_level;  // Specific EOI
        logic   rotate;       // Cleared level becomes lowest
        logic   set_prio;     // Load lowest priority from level
        level_t level;
    } isr_cmd_t;

    // ----------------------------------------
    // Command word fields
    // ----------------------------------------
    localparam int ICW1_FLAG     = 4;  // D4 set at A0=0 marks ICW1
    localparam int ICW1_LTIM     = 3;
    localparam int ICW1_IC4      = 0;
    localparam int ICW4_AEOI     = 1;
    localparam int OCW_TAG_LSB   = 3;  // D4:D3 pick OCW2 or OCW3
    localparam int OCW2_CODE_LSB = 5;  // R, SL, EOI
    localparam int OCW3_RR       = 1;
    localparam int OCW3_RIS      = 0;

    localparam logic [1:0] OCW2_TAG = 2'b00;
    localparam logic [1:0] OCW3_TAG = 2'b01;

    localparam logic [2:0] OCW2_NSEOI     = 3'b001;
    localparam logic [2:0] OCW2_SEOI      = 3'b011;
    localparam logic [2:0] OCW2_ROT_NSEOI = 3'b101;
    localparam logic [2:0] OCW2_SET_PRIO  = 3'b110;

endpackage

/* hdl/priority_resolver.sv */
`timescale 1ns/1ps

`include "pic_config.svh"

module priority_resolver
    import pic_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  irq_vec_t irr,
    input  irq_vec_t mask,
    input  irq_vec_t isr,
    input  isr_cmd_t isr_cmd,
    output logic     pend_valid,
    output level_t   pend_level,
    output logic     isr_valid,
    output level_t   isr_level,
    output logic     int_wanted
);

    level_t   lowest;    // Lowest priority level
    level_t   top_prio;  // Highest priority level
    irq_vec_t req_rot;
    irq_vec_t isr_rot;
    level_t   req_rank;  // 0 is highest priority
    level_t   isr_rank;

    // Bit 0 of the result is level n
    function automatic irq_vec_t rotate_down(irq_vec_t v, level_t n);
        irq_vec_t r;
        for (int i = 0; i < `PIC_LINES; i++)
            r[i] = v[(i + int'(n)) % `PIC_LINES];
        return r;
    endfunction

    function automatic level_t first_set(irq_vec_t v);
        level_t idx;
        idx = '0;
        for (int i = `PIC_LINES - 1; i >= 0; i--)
            if (v[i])
                idx = level_t'(i);
        return idx;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
            lowest <= '1;  // IR0 highest
        else if (isr_cmd.set_prio)
            lowest <= isr_cmd.level;
        else if (isr_cmd.rotate && isr_cmd.clear_top && isr_valid)
            lowest <= isr_level;  // Serviced level drops to the bottom
    end

    assign top_prio = lowest + 1'b1;
    assign req_rot  = rotate_down(irr & ~mask, top_prio);
    assign isr_rot  = rotate_down(isr, top_prio);
    assign req_rank = first_set(req_rot);
    assign isr_rank = first_set(isr_rot);

    assign pend_valid = |req_rot;
    assign pend_level = req_rank + top_prio;
    assign isr_valid  = |isr_rot;
    assign isr_level  = isr_rank + top_prio;

    // Fully nested mode, only a strictly higher level interrupts service
    assign int_wanted = pend_valid && (!isr_valid || req_rank < isr_rank);

endmodule

/* hdl/request_register.sv */
`timescale 1ns/1ps

`include "pic_config.svh"

module request_register
    import pic_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  irq_vec_t ir,
    input  logic     ltim,
    input  logic     ack,
    input  level_t   ack_level,
    output irq_vec_t irr
);

    irq_vec_t ir_s;
    irq_vec_t ir_prev;
    irq_vec_t ack_bit;

    input_sync #(.T(irq_vec_t), .STAGES(`PIC_SYNC_STAGES)) u_ir_sync (
        .clk       (clk),
        .rst       (rst),
        .din       (ir),
        .dout      (ir_s),
        .dout_prev (ir_prev)
    );

    always_comb
    begin
        ack_bit = '0;
        if (ack)
            ack_bit[ack_level] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            irr <= '0;
        else if (ltim)
            irr <= ir_s;  // Level mode tracks the lines
        else
            irr <= (irr & ~ack_bit) | (ir_s & ~ir_prev);  // New edge beats the clear
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module pic_tb -Mdir obj_dir -o pic_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pic_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

/* sim/pic_tb.sv */
`timescale 1ns/1ps

module pic_tb
    import pic_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        cs_n;
    logic        rd_n;
    logic        wr_n;
    logic        a0;
    logic [7:0]  d_in;
    logic        inta_n;
    irq_vec_t    ir;
    logic [7:0]  d_out;
    logic        int_req;

    // Reference model of the controller state
    irq_vec_t    ref_mask;
    irq_vec_t    ref_irr;
    irq_vec_t    ref_isr;
    level_t      ref_lowest;
    logic [4:0]  ref_base;
    logic        ref_aeoi;

    logic [7:0]  exp_vec;
    logic        vec_check;  // Set while the vector is on d_out
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          err_start;
    logic        timed_out;

    pic_8259 DUT (
        .clk     (clk),
        .rst     (rst),
        .cs_n    (cs_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .a0      (a0),
        .d_in    (d_in),
        .inta_n  (inta_n),
        .ir      (ir),
        .d_out   (d_out),
        .int_req (int_req)
    );

    always #4 clk = ~clk;  // 8 ns period

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];  // Upper bits are the most random
    endfunction

    // Expected granted level, or -1 when nothing may interrupt
    function automatic int ref_level();
        int top;
        int cand;
        int lv;
        top  = (int'(ref_lowest) + 1) % 8;
        cand = -1;
        for (int i = 7; i >= 0; i--)
        begin
            lv = (top + i) % 8;
            if (ref_irr[lv] && !ref_mask[lv])
                cand = i;  // Rank 0 is highest
        end
        if (cand < 0)
            return -1;
        for (int i = 0; i <= cand; i++)
            if (ref_isr[(top + i) % 8])
                return -1;  // Equal or higher level in service
        return (top + cand) % 8;
    endfunction

    function automatic int ref_top_isr();
        int top;
        top = (int'(ref_lowest) + 1) % 8;
        for (int i = 0; i < 8; i++)
            if (ref_isr[(top + i) % 8])
                return (top + i) % 8;
        return -1;
    endfunction

    // Vector compare during the second INTA pulse
    always @(negedge clk)
    begin
        #1;
        if (vec_check)
        begin
            checks++;
            if (d_out !== exp_vec)
            begin
                errors++;
                $display("Mismatch at %0t: vector %h, expected %h", $time, d_out, exp_vec);
            end
        end
    end

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------
    task automatic bus_write(input logic addr, input logic [7:0] data);
        @(negedge clk);
        a0   = addr;
        d_in = data;
        cs_n = 1'b0;
        wr_n = 1'b0;
        repeat (6) @(negedge clk);
        wr_n = 1'b1;  // Takes effect 3 cycles on
        repeat (6) @(negedge clk);
        cs_n = 1'b1;
        repeat (6) @(negedge clk);
    endtask

    task automatic check_read(input logic addr, input logic [7:0] exp_val, input string what);
        logic [7:0] got;
        @(negedge clk);
        a0   = addr;
        cs_n = 1'b0;
        rd_n = 1'b0;
        repeat (6) @(negedge clk);
        got  = d_out;  // Valid from 3 cycles after rd_n falls
        rd_n = 1'b1;
        cs_n = 1'b1;
        repeat (6) @(negedge clk);
        checks++;
        if (got !== exp_val)
        begin
            errors++;
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp_val);
        end
    endtask

    task automatic pulse_ir(input irq_vec_t lines);
        @(negedge clk);
        ir = lines;
        repeat (4) @(negedge clk);
        ir = '0;
        repeat (6) @(negedge clk);
        ref_irr = ref_irr | lines;  // Edge mode latches the rise
    endtask

    task automatic wait_int();
        int n;
        n = 0;
        while (int_req !== 1'b1 && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (int_req !== 1'b1)
        begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout at %0t: int_req did not rise within 200 cycles", $time);
        end
    endtask

    task automatic hold_int_low(input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            if (int_req !== 1'b0)
            begin
                errors++;
                $display("Mismatch at %0t: int_req high with no winning request", $time);
                break;
            end
        end
        checks++;
    endtask

    // Two INTA pulses, vector checked on the second
    task automatic acknowledge();
        int lvl;
        lvl = ref_level();
        if (timed_out)
            return;
        if (lvl < 0)
        begin
            errors++;
            $display("Acknowledge at %0t found no request that should win", $time);
            return;
        end
        exp_vec = {ref_base, level_t'(lvl)};
        @(negedge clk);
        inta_n = 1'b0;
        repeat (6) @(negedge clk);
        inta_n = 1'b1;
        repeat (6) @(negedge clk);
        inta_n = 1'b0;
        repeat (4) @(negedge clk);
        vec_check = 1'b1;
        repeat (2) @(negedge clk);
        vec_check = 1'b0;
        inta_n = 1'b1;
        repeat (6) @(negedge clk);
        ref_irr[lvl] = 1'b0;
        ref_isr[lvl] = !ref_aeoi;  // AEOI clears on the second rise
    endtask

    task automatic eoi_nonspecific(input logic rotate);
        int top;
        bus_write(1'b0, rotate ? 8'hA0 : 8'h20);
        top = ref_top_isr();
        if (top >= 0)
        begin
            ref_isr[top] = 1'b0;
            if (rotate)
                ref_lowest = level_t'(top);
        end
    endtask

    task automatic eoi_specific(input level_t lvl);
        bus_write(1'b0, {5'b01100, lvl});
        ref_isr[lvl] = 1'b0;
    endtask

    task automatic set_priority(input level_t lvl);
        bus_write(1'b0, {5'b11000, lvl});
        ref_lowest = lvl;
    endtask

    task automatic write_mask(input irq_vec_t m);
        bus_write(1'b1, m);  // OCW1
        ref_mask = m;
    endtask

    task automatic select_read(input logic isr_sel);
        bus_write(1'b0, {7'b0000101, isr_sel});  // OCW3 with RR set
    endtask

    task automatic init_pic(input logic [4:0] base, input logic icw4, input logic aeoi);
        bus_write(1'b0, icw4 ? 8'h13 : 8'h12);  // Edge mode, single
        bus_write(1'b1, {base, 3'b000});
        if (icw4)
            bus_write(1'b1, {6'b000000, aeoi, 1'b1});
        ref_mask   = '0;
        ref_lowest = 3'd7;
        ref_base   = base;
        ref_aeoi   = icw4 & aeoi;
    endtask

    // Acknowledge and EOI until nothing is left
    task automatic drain(input logic rotate);
        for (int n = 0; n < 24; n++)
        begin
            if (timed_out)
                break;
            if (ref_level() >= 0)
            begin
                wait_int();
                acknowledge();
                eoi_nonspecific(rotate);
            end
            else if (ref_isr != '0)
            begin
                hold_int_low(4);  // Pending levels blocked by service
                eoi_nonspecific(rotate);
            end
            else
                break;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - err_start);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_mask();
        err_start = errors;
        checks++;
        if (d_out !== 8'h00 || int_req !== 1'b0)
        begin
            errors++;
            $display("Mismatch at %0t: outputs not idle after reset", $time);
        end
        check_read(1'b1, 8'h00, "mask after reset");
        init_pic(5'b00100, 1'b1, 1'b0);
        write_mask(8'hFF);
        check_read(1'b1, 8'hFF, "mask");
        write_mask(8'hA5);
        check_read(1'b1, 8'hA5, "mask");
        write_mask(lcg_byte());
        check_read(1'b1, ref_mask, "mask");
        write_mask(8'h00);
        hold_int_low(50);
        end_test("mask_readback");
    endtask

    task automatic test_vectors();
        err_start = errors;
        init_pic(5'b10101, 1'b0, 1'b0);
        select_read(1'b1);
        for (int l = 0; l < 8; l++)
        begin
            pulse_ir(8'h01 << l);
            wait_int();
            acknowledge();
            eoi_specific(level_t'(l));
            check_read(1'b0, 8'h00, "ISR after specific EOI");
        end
        end_test("vectors");
    endtask

    task automatic test_masking();
        err_start = errors;
        write_mask(8'hFF);
        pulse_ir(8'hFF);
        hold_int_low(200);
        write_mask(8'hDF);  // Only IR5 open
        wait_int();
        acknowledge();
        eoi_specific(3'd5);
        write_mask(8'h00);
        drain(1'b0);
        end_test("masking");
    endtask

    task automatic test_nesting();
        err_start = errors;
        pulse_ir(8'h10);
        wait_int();
        acknowledge();    // IR4 stays in service
        pulse_ir(8'h68);  // IR3, IR5, IR6
        wait_int();       // IR3 outranks IR4
        acknowledge();
        select_read(1'b1);
        check_read(1'b0, 8'h18, "ISR while nested");
        drain(1'b0);
        end_test("nesting");
    endtask

    task automatic random_phase(input logic rotate);
        logic [7:0] pat;
        for (int n = 0; n < 5; n++)
        begin
            pat = lcg_byte();
            if (pat == 8'h00)
                pat = 8'h81;
            pulse_ir(pat);
            drain(rotate);
        end
    endtask

    task automatic test_random();
        err_start = errors;
        random_phase(1'b0);
        set_priority(3'd4);  // IR5 highest
        random_phase(1'b0);
        random_phase(1'b1);
        end_test("random");
    endtask

    task automatic test_aeoi();
        err_start = errors;
        init_pic(5'b01110, 1'b1, 1'b1);
        pulse_ir(8'hFF);
        select_read(1'b0);
        check_read(1'b0, 8'hFF, "IRR before acknowledge");
        select_read(1'b1);
        for (int n = 0; n < 8; n++)
        begin
            wait_int();
            acknowledge();
            check_read(1'b0, 8'h00, "ISR in AEOI mode");
        end
        end_test("auto_eoi");
    endtask

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        cs_n      = 1'b1;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        a0        = 1'b0;
        d_in      = 8'h00;
        inta_n    = 1'b1;
        ir        = '0;
        ref_mask  = '0;
        ref_irr   = '0;
        ref_isr   = '0;
        ref_lowest = 3'd7;
        ref_base  = '0;
        ref_aeoi  = 1'b0;
        exp_vec   = 8'h00;
        vec_check = 1'b0;
        lcg_state = 32'h9706_2d6d;
        checks    = 0;
        errors    = 0;
        err_start = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_mask();
        if (!timed_out)
            test_vectors();
        if (!timed_out)
            test_masking();
        if (!timed_out)
            test_nesting();
        if (!timed_out)
            test_random();
        if (!timed_out)
            test_aeoi();

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
